/* rtl/decodeGroup11.sv */
// Decoder for the 11xxx01x opcode family, gated by the first timing step

`default_nettype none

`include "decoder_settings.svh"

module decodeGroup11
    import decoderPkg::*;
(
    input  wire opcodeT opcode,
    input  wire stepT   step,
    output condT        jpCond,
    output logic        jpNn,
    output logic        prefixCb,
    output logic        outNA,
    output logic        inAN,
    output logic        exSpHl,
    output logic        exDeHl,
    output logic        setIff,
    output logic        resetIff
);

    // ccc field values of the 11ccc011 single instructions
    localparam logic [2:0] CccJpNn   = 3'd0; // C3
    localparam logic [2:0] CccPrefix = 3'd1; // CB
    localparam logic [2:0] CccOutNA  = 3'd2; // D3
    localparam logic [2:0] CccInAN   = 3'd3; // DB
    localparam logic [2:0] CccExSpHl = 3'd4; // E3
    localparam logic [2:0] CccExDeHl = 3'd5; // EB
    localparam logic [2:0] CccDi     = 3'd6; // F3
    localparam logic [2:0] CccEi     = 3'd7; // FB

    logic       active;
    logic       inGroup;
    logic       rankJpCc;
    logic       rankSingle;
    logic [2:0] ccc;
    condT       cccOneHot;
    condT       single;

    assign active = step[0]; // Only the first step issues strobes
    assign ccc    = opcode[5:3];

    // Covers 11ccc010 and 11ccc011
    assign inGroup = (opcode[7:6] == `GROUP_TOP) && (opcode[2:1] == `GROUP_LOW);

    // Two sub-ranks split on bit 0
    assign rankJpCc   = active && inGroup && !opcode[0];
    assign rankSingle = active && inGroup && opcode[0];

    assign cccOneHot = condT'(1) << ccc;

    assign jpCond = rankJpCc ? cccOneHot : '0;
    assign single = rankSingle ? cccOneHot : '0;

    assign jpNn     = single[CccJpNn];
    assign prefixCb = single[CccPrefix];
    assign outNA    = single[CccOutNA];
    assign inAN     = single[CccInAN];
    assign exSpHl   = single[CccExSpHl];
    assign exDeHl   = single[CccExDeHl];
    assign resetIff = single[CccDi]; // DI
    assign setIff   = single[CccEi]; // EI

endmodule

`default_nettype wire

/* rtl/decodeTop.sv */
// Top level of the decode slice: fetch, instruction register, decoder and flags

`default_nettype none

module decodeTop
    import decoderPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire logic   opStrobe,
    input  wire opcodeT opData,
    output logic        busy,
    output opcodeT      lastOpcode,
    output condT        jpCond,
    output logic        jpNn,
    output logic        prefixCb,
    output logic        outNA,
    output logic        inAN,
    output logic        exSpHl,
    output logic        exDeHl,
    output logic        setIff,
    output logic        resetIff,
    output logic        iff1,
    output logic        iff2,
    output logic        cbMode,
    output logic        exDeSwap
);

    logic   load;
    opcodeT loadData;
    opcodeT opcode;
    stepT   step;

    opcodeFetch uFetch (
        .clk      (clk),
        .rstN     (rstN),
        .opStrobe (opStrobe),
        .opData   (opData),
        .load     (load),
        .loadData (loadData),
        .step     (step),
        .busy     (busy)
    );

    instrRegister uInstr (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .loadData   (loadData),
        .opcode     (opcode),
        .prevOpcode (lastOpcode)
    );

    decodeGroup11 uDecode (
        .opcode   (opcode),
        .step     (step),
        .jpCond   (jpCond),
        .jpNn     (jpNn),
        .prefixCb (prefixCb),
        .outNA    (outNA),
        .inAN     (inAN),
        .exSpHl   (exSpHl),
        .exDeHl   (exDeHl),
        .setIff   (setIff),
        .resetIff (resetIff)
    );

    machineFlags uFlags (
        .clk        (clk),
        .rstN       (rstN),
        .load       (load),
        .setIff     (setIff),
        .resetIff   (resetIff),
        .setPrefix  (prefixCb),
        .toggleExDe (exDeHl),
        .iff1       (iff1),
        .iff2       (iff2),
        .cbMode     (cbMode),
        .exDeSwap   (exDeSwap)
    );

endmodule

`default_nettype wire

/* rtl/decoderPkg.sv */
// Shared vector types and the fetch state enum for the group decode slice

`default_nettype none

`include "decoder_settings.svh"

package decoderPkg;

    // One opcode byte as held in the instruction register
    typedef logic [`OPCODE_WIDTH-1:0] opcodeT;

    // One-hot timing step, bit 0 is the first step
    typedef logic [`STEP_COUNT-1:0] stepT;

    // One-hot jump condition select, indexed by the ccc field
    typedef logic [7:0] condT;

    // Fetch sequencer states
    typedef enum logic {
        IDLE,
        STEPPING
    } fetchStateT;

endpackage

`default_nettype wire

/* rtl/decoder_settings.svh */
// Opcode width, timing step count and the 11xxx01x group pattern

`ifndef DECODER_SETTINGS_SVH
`define DECODER_SETTINGS_SVH

// One opcode byte
`define OPCODE_WIDTH 8

// Timing steps per instruction, one-hot
`define STEP_COUNT 5

// Fixed top two bits of the decoded family
`define GROUP_TOP 2'b11

// Bits 2:1 of the decoded family
`define GROUP_LOW 2'b01

`endif

/* rtl/instrRegister.sv */
// Instruction register holding the current and the previous opcode

`default_nettype none

module instrRegister
    import decoderPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire logic   load,
    input  wire opcodeT loadData,
    output opcodeT      opcode,
    output opcodeT      prevOpcode
);

    // Previous opcode shifts in on every load, ready for prefix tracking
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            opcode     <= '0;
            prevOpcode <= '0;
        end else if (load) begin
            prevOpcode <= opcode;
            opcode     <= loadData;
        end
    end

endmodule

`default_nettype wire

/* rtl/machineFlags.sv */
// Interrupt enable, CB prefix and DE/HL exchange flag register

`default_nettype none

module machineFlags
    import decoderPkg::*;
(
    input  wire logic clk,
    input  wire logic rstN,
    input  wire logic load,
    input  wire logic setIff,
    input  wire logic resetIff,
    input  wire logic setPrefix,
    input  wire logic toggleExDe,
    output logic      iff1,
    output logic      iff2,
    output logic      cbMode,
    output logic      exDeSwap
);

    // EI and DI move both flip-flops together
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            iff1 <= 1'b0;
            iff2 <= 1'b0;
        end else if (setIff) begin
            iff1 <= 1'b1;
            iff2 <= 1'b1;
        end else if (resetIff) begin
            iff1 <= 1'b0;
            iff2 <= 1'b0;
        end
    end

    // Prefix lasts until the next opcode is loaded
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            cbMode <= 1'b0;
        end else if (setPrefix) begin
            cbMode <= 1'b1; // Wins over a load in the same cycle
        end else if (load) begin
            cbMode <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            exDeSwap <= 1'b0;
        end else if (toggleExDe) begin
            exDeSwap <= ~exDeSwap; // Register bank swap
        end
    end

endmodule

`default_nettype wire

/* rtl/opcodeFetch.sv */
// Fetch sequencer: opcode strobe acceptance, register load and timing step walk

`default_nettype none

`include "decoder_settings.svh"

module opcodeFetch
    import decoderPkg::*;
(
    input  wire logic   clk,
    input  wire logic   rstN,
    input  wire logic   opStrobe,
    input  wire opcodeT opData,
    output logic        load,
    output opcodeT      loadData,
    output stepT        step,
    output logic        busy
);

    fetchStateT state;
    logic       lastStep;
    logic       accept;

    assign lastStep = step[`STEP_COUNT-1];

    // The final step frees the sequencer so instructions can run back to back
    assign accept = opStrobe && (state == IDLE || lastStep);

    assign load     = accept; // Register captures at the same edge that starts step 0
    assign loadData = opData;
    assign busy     = (state == STEPPING);

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= IDLE;
            step  <= '0;
        end else if (accept) begin
            state <= STEPPING;
            step  <= stepT'(1); // First timing step
        end else if (state == STEPPING) begin
            step <= step << 1; // Bit 4 shifts out to zero
            if (lastStep) begin
                state <= IDLE;
            end
        end
    end

endmodule

`default_nettype wire

/* tb.f */
+incdir+rtl
rtl/decoderPkg.sv
rtl/opcodeFetch.sv
rtl/instrRegister.sv
rtl/decodeGroup11.sv
rtl/machineFlags.sv
rtl/decodeTop.sv
verification/decodeTb.sv

/* verification/decodeTb.sv */
// Testbench for decodeTop: clock, reset, stimulus, reference model, compare tasks and timeout

`default_nettype none

module decodeTb
    import decoderPkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NumAll        = 256;
    localparam int NumCond       = 9;
    localparam int NumIff        = 24;
    localparam int NumPrefix     = 12;
    localparam int NumRandom     = 40;
    localparam int NumInstr      = NumAll + NumCond + NumIff + NumPrefix + NumRandom;
    localparam int TimeoutCycles = NumInstr * 8 + 100;

    logic   clk;
    logic   rstN;
    logic   opStrobe;
    opcodeT opData;
    logic   busy;
    opcodeT lastOpcode;
    condT   jpCond;
    logic   jpNn;
    logic   prefixCb;
    logic   outNA;
    logic   inAN;
    logic   exSpHl;
    logic   exDeHl;
    logic   setIff;
    logic   resetIff;
    logic   iff1;
    logic   iff2;
    logic   cbMode;
    logic   exDeSwap;

    logic   newInstr;   // Marks a strobe that should start an instruction
    opcodeT curModel;
    opcodeT prevModel;
    int     phase;      // Cycles since the last accepted strobe, 100 when idle
    logic   refIff;
    logic   refCb;
    logic   refExDe;
    int     cycleCount;
    int unsigned seedDummy;

    opcodeT prefixSeq [NumPrefix] = '{8'hCB, 8'h00, 8'hCB, 8'hCB, 8'hEB, 8'hCB,
                                     8'hEB, 8'hEB, 8'h3E, 8'hCB, 8'hC3, 8'hEB};

    decodeTop dut (
        .clk        (clk),
        .rstN       (rstN),
        .opStrobe   (opStrobe),
        .opData     (opData),
        .busy       (busy),
        .lastOpcode (lastOpcode),
        .jpCond     (jpCond),
        .jpNn       (jpNn),
        .prefixCb   (prefixCb),
        .outNA      (outNA),
        .inAN       (inAN),
        .exSpHl     (exSpHl),
        .exDeHl     (exDeHl),
        .setIff     (setIff),
        .resetIff   (resetIff),
        .iff1       (iff1),
        .iff2       (iff2),
        .cbMode     (cbMode),
        .exDeSwap   (exDeSwap)
    );

    always #2 clk = ~clk; // 4 ns period

    // Expected strobes from the opcode table
    // Bits 15:8 jpCond, then jpNn, prefixCb, outNA, inAN, exSpHl, exDeHl, setIff, resetIff
    function automatic logic [15:0] refStrobes(input opcodeT op);
        logic [15:0] r;
        r = '0;
        if (op[7:6] == 2'b11 && op[2:0] == 3'b010) begin
            r[8 + op[5:3]] = 1'b1; // JP cc,nn
        end
        case (op)
            8'hC3: r[7] = 1'b1;
            8'hCB: r[6] = 1'b1;
            8'hD3: r[5] = 1'b1;
            8'hDB: r[4] = 1'b1;
            8'hE3: r[3] = 1'b1;
            8'hEB: r[2] = 1'b1;
            8'hFB: r[1] = 1'b1; // EI
            8'hF3: r[0] = 1'b1; // DI
            default: ;
        endcase
        return r;
    endfunction

    task automatic reportFailure();
        $display("SIMULATION FAILED");
        $fatal(1, "Stopped at the first failure");
    endtask

    task automatic checkStrobe(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expVal, actVal, $time);
            reportFailure();
        end
    endtask

    task automatic checkFlag(input string name, input logic expVal, input logic actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expVal, actVal, $time);
            reportFailure();
        end
    endtask

    task automatic checkCond(input string name, input condT expVal, input condT actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expVal, actVal, $time);
            reportFailure();
        end
    endtask

    task automatic checkOpcode(input string name, input opcodeT expVal, input opcodeT actVal);
        if (actVal !== expVal) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h at %0t", name, expVal, actVal, $time);
            reportFailure();
        end
    endtask

    // One instruction, optionally followed by strobes that must be ignored
    task automatic issueOp(input opcodeT op, input logic withExtras, input logic backToBack);
        int k;
        @(negedge clk);
        opStrobe = 1'b1;
        opData   = op;
        newInstr = 1'b1;
        for (k = 0; k < 4; k++) begin
            @(negedge clk); // Sampled while steps 0 to 3 run
            newInstr = 1'b0;
            opStrobe = withExtras && ($urandom % 2 == 1);
            opData   = opcodeT'($urandom);
        end
        // Back to back leaves the next strobe to land on the final step
        if (!backToBack) begin
            @(negedge clk);
            opStrobe = 1'b0;
            while (busy) begin
                @(negedge clk);
            end
        end
    endtask

    // Acceptance model from the timing rules
    always @(posedge clk) begin
        if (rstN) begin
            if (opStrobe && newInstr) begin
                prevModel = curModel;
                curModel  = opData;
                phase     = 0;
            end else if (phase < 100) begin
                phase = phase + 1;
            end
        end
    end

    always @(negedge clk) begin : compareOutputs
        logic [15:0] expStrobes;
        if (rstN) begin
            expStrobes = (phase == 0) ? refStrobes(curModel) : 16'h0000;
            checkStrobe("busy", phase <= 4, busy);
            checkOpcode("lastOpcode", prevModel, lastOpcode);
            checkCond("jpCond", expStrobes[15:8], jpCond);
            checkStrobe("jpNn", expStrobes[7], jpNn);
            checkStrobe("prefixCb", expStrobes[6], prefixCb);
            checkStrobe("outNA", expStrobes[5], outNA);
            checkStrobe("inAN", expStrobes[4], inAN);
            checkStrobe("exSpHl", expStrobes[3], exSpHl);
            checkStrobe("exDeHl", expStrobes[2], exDeHl);
            checkStrobe("setIff", expStrobes[1], setIff);
            checkStrobe("resetIff", expStrobes[0], resetIff);
            if (phase == 1) begin // Flags have taken this instruction's strobes
                if (curModel == 8'hFB) begin
                    refIff = 1'b1;
                end else if (curModel == 8'hF3) begin
                    refIff = 1'b0;
                end
                refCb = (curModel == 8'hCB);
                if (curModel == 8'hEB) begin
                    refExDe = ~refExDe;
                end
            end
            if (phase == 0) begin
                checkFlag("cbMode", 1'b0, cbMode); // Cleared by the load
            end else begin
                checkFlag("iff1", refIff, iff1);
                checkFlag("iff2", refIff, iff2);
                checkFlag("cbMode", refCb, cbMode);
                checkFlag("exDeSwap", refExDe, exDeSwap);
            end
        end
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            reportFailure();
        end
    end

    initial begin
        int     i;
        opcodeT op;
        clk        = 1'b0;
        rstN       = 1'b0;
        opStrobe   = 1'b0;
        opData     = '0;
        newInstr   = 1'b0;
        curModel   = '0;
        prevModel  = '0;
        phase      = 100;
        refIff     = 1'b0;
        refCb      = 1'b0;
        refExDe    = 1'b0;
        cycleCount = 0;
        seedDummy  = $urandom(32'h2609b9c9);

        repeat (3) @(negedge clk);
        rstN = 1'b1;

        // Reset state
        @(negedge clk);
        checkStrobe("busy", 1'b0, busy);
        checkOpcode("lastOpcode", 8'h00, lastOpcode);
        checkCond("jpCond", 8'h00, jpCond);
        checkFlag("iff1", 1'b0, iff1);
        checkFlag("cbMode", 1'b0, cbMode);

        for (i = 0; i < NumAll; i++) begin
            issueOp(opcodeT'(i), 1'b0, 1'b0);
        end

        // JP cc,nn for every condition, then JP nn
        for (i = 0; i < 8; i++) begin
            issueOp({2'b11, 3'(i), 3'b010}, 1'b0, 1'b0);
        end
        issueOp(8'hC3, 1'b0, 1'b0);

        for (i = 0; i < NumIff; i++) begin
            op = ($urandom % 2 == 1) ? 8'hFB : 8'hF3;
            issueOp(op, 1'b0, 1'b0);
        end

        for (i = 0; i < NumPrefix; i++) begin
            issueOp(prefixSeq[i], 1'b0, 1'b0);
        end

        // Random mix with extra strobes while busy, run back to back
        for (i = 0; i < NumRandom; i++) begin
            if ($urandom % 2 == 1) begin
                op = {2'b11, 3'($urandom), 2'b01, 1'($urandom)};
            end else begin
                op = opcodeT'($urandom);
            end
            issueOp(op, 1'b1, i < NumRandom - 1);
        end

        @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire
